// ==== src/simd_alu_pkg.sv ====
package simd_alu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] ctrl_word_t;
  typedef logic [11:0] opcode_t;
  typedef logic [4:0]  shamt_t;
  typedef logic [63:0] product_t;

  // Control word fields
  localparam int FMT_MSB  = 31;
  localparam int FMT_LSB  = 24;
  localparam int OPC_MSB  = 11;
  localparam int ABS1_POS = 16;
  localparam int ABS2_POS = 17;
  localparam int NEG1_POS = 20;
  localparam int NEG2_POS = 21;

  localparam int MUL_WAIT_CYCLES = 3;
  localparam int MUL_CNT_W       = $clog2(MUL_WAIT_CYCLES);
  localparam logic [MUL_CNT_W-1:0] MUL_CNT_LAST = MUL_CNT_W'(MUL_WAIT_CYCLES - 1);

  localparam opcode_t OPC_V_MOV_B32      = 12'h001;  // VOP1
  localparam opcode_t OPC_V_CNDMASK_B32  = 12'h000;  // VOP2 from here
  localparam opcode_t OPC_V_MAX_I32      = 12'h012;
  localparam opcode_t OPC_V_MIN_U32      = 12'h013;
  localparam opcode_t OPC_V_MAX_U32      = 12'h014;
  localparam opcode_t OPC_V_LSHRREV_B32  = 12'h016;
  localparam opcode_t OPC_V_ASHRREV_I32  = 12'h018;
  localparam opcode_t OPC_V_LSHLREV_B32  = 12'h01A;
  localparam opcode_t OPC_V_AND_B32      = 12'h01B;
  localparam opcode_t OPC_V_OR_B32       = 12'h01C;
  localparam opcode_t OPC_V_ADD_I32      = 12'h025;
  localparam opcode_t OPC_V_SUB_I32      = 12'h026;
  localparam opcode_t OPC_V_SUBREV_I32   = 12'h027;
  localparam opcode_t OPC_V_ADDC_U32     = 12'h028;
  localparam opcode_t OPC_V3_MAX_U32     = 12'h114;  // VOP3A encodings
  localparam opcode_t OPC_V3_AND_B32     = 12'h11B;
  localparam opcode_t OPC_V_MUL_LO_U32   = 12'h169;
  localparam opcode_t OPC_V_MUL_HI_U32   = 12'h16A;
  localparam opcode_t OPC_V_CMP_I32_BASE = 12'h080;  // Eight signed compares
  localparam opcode_t OPC_V_CMP_U32_BASE = 12'h0C0;  // Eight unsigned compares

  typedef enum logic [7:0] {
    fmt_vop1  = 8'h01,
    fmt_vop2  = 8'h02,
    fmt_vopc  = 8'h04,
    fmt_vop3a = 8'h08
  } fmt_e;

  typedef enum logic [4:0] {
    op_mov, op_add, op_sub, op_subrev, op_addc, op_and, op_or,
    op_lshl, op_lshr, op_ashr, op_max_u, op_max_i, op_min_u,
    op_cndmask, op_cmp, op_mul_lo, op_mul_hi
  } alu_op_e;

  typedef enum logic [2:0] {
    cmp_f, cmp_lt, cmp_eq, cmp_le, cmp_gt, cmp_lg, cmp_ge, cmp_tru
  } cmp_cond_e;

  typedef enum logic [1:0] {
    st_idle, st_exec, st_mul_wait
  } ctrl_state_e;

  typedef struct packed {
    ctrl_word_t ctrl;
    word_t      src1;
    word_t      src2;
    logic       vcc;
    logic       exec;
  } alu_req_t;

  typedef struct packed {
    alu_op_e   op;
    cmp_cond_e cond;
    logic      cmp_unsigned;
    logic      is_mul;
    logic      exec;
    logic      illegal;
  } decoded_op_t;

  typedef struct packed {
    word_t vgpr_data;
    logic  vgpr_write;
    logic  vcc;
    logic  illegal;
  } alu_result_t;

endpackage

// ==== src/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      load,
  input  simd_alu_pkg::ctrl_word_t  ctrl,
  input  logic                      exec,
  output simd_alu_pkg::decoded_op_t dec
);

  logic [7:0]                fmt;
  simd_alu_pkg::opcode_t     opc;
  simd_alu_pkg::opcode_t     cmp_base;
  logic                      is_cmp;
  simd_alu_pkg::decoded_op_t dec_next;

  assign fmt      = ctrl[simd_alu_pkg::FMT_MSB:simd_alu_pkg::FMT_LSB];
  assign opc      = ctrl[simd_alu_pkg::OPC_MSB:0];
  assign cmp_base = {opc[simd_alu_pkg::OPC_MSB:3], 3'b000};  // Condition sits in bits 2:0
  assign is_cmp   = (cmp_base == simd_alu_pkg::OPC_V_CMP_I32_BASE) ||
                    (cmp_base == simd_alu_pkg::OPC_V_CMP_U32_BASE);

  always_comb
  begin
    dec_next              = '0;
    dec_next.op           = simd_alu_pkg::op_mov;
    dec_next.cond         = simd_alu_pkg::cmp_cond_e'(opc[2:0]);
    dec_next.cmp_unsigned = opc[6];
    dec_next.exec         = exec;
    case (fmt)
      simd_alu_pkg::fmt_vop1:
      begin
        if (opc != simd_alu_pkg::OPC_V_MOV_B32)
          dec_next.illegal = 1'b1;
      end
      simd_alu_pkg::fmt_vop2:
      begin
        case (opc)
          simd_alu_pkg::OPC_V_ADD_I32:     dec_next.op = simd_alu_pkg::op_add;
          simd_alu_pkg::OPC_V_SUB_I32:     dec_next.op = simd_alu_pkg::op_sub;
          simd_alu_pkg::OPC_V_SUBREV_I32:  dec_next.op = simd_alu_pkg::op_subrev;
          simd_alu_pkg::OPC_V_ADDC_U32:    dec_next.op = simd_alu_pkg::op_addc;
          simd_alu_pkg::OPC_V_AND_B32:     dec_next.op = simd_alu_pkg::op_and;
          simd_alu_pkg::OPC_V_OR_B32:      dec_next.op = simd_alu_pkg::op_or;
          simd_alu_pkg::OPC_V_LSHLREV_B32: dec_next.op = simd_alu_pkg::op_lshl;
          simd_alu_pkg::OPC_V_LSHRREV_B32: dec_next.op = simd_alu_pkg::op_lshr;
          simd_alu_pkg::OPC_V_ASHRREV_I32: dec_next.op = simd_alu_pkg::op_ashr;
          simd_alu_pkg::OPC_V_MAX_U32:     dec_next.op = simd_alu_pkg::op_max_u;
          simd_alu_pkg::OPC_V_MAX_I32:     dec_next.op = simd_alu_pkg::op_max_i;
          simd_alu_pkg::OPC_V_MIN_U32:     dec_next.op = simd_alu_pkg::op_min_u;
          simd_alu_pkg::OPC_V_CNDMASK_B32: dec_next.op = simd_alu_pkg::op_cndmask;
          default:                         dec_next.illegal = 1'b1;
        endcase
      end
      simd_alu_pkg::fmt_vopc:
      begin
        if (is_cmp)
          dec_next.op = simd_alu_pkg::op_cmp;
        else
          dec_next.illegal = 1'b1;
      end
      simd_alu_pkg::fmt_vop3a:
      begin
        if (is_cmp)
          dec_next.op = simd_alu_pkg::op_cmp;
        else
        begin
          case (opc)
            simd_alu_pkg::OPC_V3_AND_B32: dec_next.op = simd_alu_pkg::op_and;
            simd_alu_pkg::OPC_V3_MAX_U32: dec_next.op = simd_alu_pkg::op_max_u;
            simd_alu_pkg::OPC_V_MUL_LO_U32:
            begin
              dec_next.op     = simd_alu_pkg::op_mul_lo;
              dec_next.is_mul = 1'b1;
            end
            simd_alu_pkg::OPC_V_MUL_HI_U32:
            begin
              dec_next.op     = simd_alu_pkg::op_mul_hi;
              dec_next.is_mul = 1'b1;
            end
            default: dec_next.illegal = 1'b1;
          endcase
        end
      end
      default: dec_next.illegal = 1'b1;  // Unknown format
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      dec <= '0;
    else if (load)
      dec <= dec_next;
  end

endmodule

// ==== src/operand_modifier.sv ====
`timescale 1ns/1ps

module operand_modifier (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load,
  input  simd_alu_pkg::alu_req_t req,
  output simd_alu_pkg::word_t    opa,
  output simd_alu_pkg::word_t    opb,
  output logic                   vcc_in
);

  logic is_vop3a;

  // Abs first, then neg on the absolute value
  function automatic simd_alu_pkg::word_t apply_mod(input simd_alu_pkg::word_t src,
                                                    input logic abs_en,
                                                    input logic neg_en);
    simd_alu_pkg::word_t val;
    val = (abs_en && src[31]) ? -src : src;
    return neg_en ? -val : val;
  endfunction

  assign is_vop3a = (req.ctrl[simd_alu_pkg::FMT_MSB:simd_alu_pkg::FMT_LSB] ==
                     simd_alu_pkg::fmt_vop3a);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      opa    <= '0;
      opb    <= '0;
      vcc_in <= 1'b0;
    end
    else if (load)
    begin
      opa    <= apply_mod(req.src1, is_vop3a && req.ctrl[simd_alu_pkg::ABS1_POS],
                          is_vop3a && req.ctrl[simd_alu_pkg::NEG1_POS]);
      opb    <= apply_mod(req.src2, is_vop3a && req.ctrl[simd_alu_pkg::ABS2_POS],
                          is_vop3a && req.ctrl[simd_alu_pkg::NEG2_POS]);
      vcc_in <= req.vcc;
    end
  end

endmodule

// ==== src/vector_int_unit.sv ====
`timescale 1ns/1ps

module vector_int_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      result_load,
  input  simd_alu_pkg::decoded_op_t dec,
  input  simd_alu_pkg::word_t       opa,
  input  simd_alu_pkg::word_t       opb,
  input  logic                      vcc_in,
  input  simd_alu_pkg::product_t    product,
  output simd_alu_pkg::alu_result_t result
);

  simd_alu_pkg::alu_result_t res_next;
  simd_alu_pkg::shamt_t      shamt;
  logic                      lt;
  logic                      eq;
  logic                      cmp_true;

  assign shamt = opa[4:0];  // REV shifts take the amount from source 1
  assign lt    = dec.cmp_unsigned ? (opa < opb) : ($signed(opa) < $signed(opb));
  assign eq    = (opa == opb);

  always_comb
  begin
    case (dec.cond)
      simd_alu_pkg::cmp_f:   cmp_true = 1'b0;
      simd_alu_pkg::cmp_lt:  cmp_true = lt;
      simd_alu_pkg::cmp_eq:  cmp_true = eq;
      simd_alu_pkg::cmp_le:  cmp_true = lt | eq;
      simd_alu_pkg::cmp_gt:  cmp_true = ~(lt | eq);
      simd_alu_pkg::cmp_lg:  cmp_true = ~eq;
      simd_alu_pkg::cmp_ge:  cmp_true = ~lt;
      default:               cmp_true = 1'b1;  // TRU
    endcase
  end

  always_comb
  begin
    res_next            = '0;
    res_next.vcc        = vcc_in;
    res_next.vgpr_write = 1'b1;
    if (!dec.exec)
      res_next.vgpr_write = 1'b0;  // Lane masked off
    else if (dec.illegal)
    begin
      res_next.vgpr_write = 1'b0;
      res_next.illegal    = 1'b1;
    end
    else
    begin
      case (dec.op)
        simd_alu_pkg::op_mov:     res_next.vgpr_data = opa;
        simd_alu_pkg::op_add:     {res_next.vcc, res_next.vgpr_data} = {1'b0, opa} + {1'b0, opb};
        simd_alu_pkg::op_sub:     {res_next.vcc, res_next.vgpr_data} = {1'b0, opa} - {1'b0, opb};
        simd_alu_pkg::op_subrev:  {res_next.vcc, res_next.vgpr_data} = {1'b0, opb} - {1'b0, opa};
        simd_alu_pkg::op_addc:
          {res_next.vcc, res_next.vgpr_data} = {1'b0, opa} + {1'b0, opb} + {32'b0, vcc_in};
        simd_alu_pkg::op_and:     res_next.vgpr_data = opa & opb;
        simd_alu_pkg::op_or:      res_next.vgpr_data = opa | opb;
        simd_alu_pkg::op_lshl:    res_next.vgpr_data = opb << shamt;
        simd_alu_pkg::op_lshr:    res_next.vgpr_data = opb >> shamt;
        simd_alu_pkg::op_ashr:    res_next.vgpr_data = $signed(opb) >>> shamt;  // Sign fill
        simd_alu_pkg::op_max_u:   res_next.vgpr_data = (opa >= opb) ? opa : opb;
        simd_alu_pkg::op_max_i:   res_next.vgpr_data = ($signed(opa) >= $signed(opb)) ? opa : opb;
        simd_alu_pkg::op_min_u:   res_next.vgpr_data = (opa <= opb) ? opa : opb;
        simd_alu_pkg::op_cndmask: res_next.vgpr_data = vcc_in ? opb : opa;
        simd_alu_pkg::op_mul_lo:  res_next.vgpr_data = product[31:0];
        simd_alu_pkg::op_mul_hi:  res_next.vgpr_data = product[63:32];
        simd_alu_pkg::op_cmp:
        begin
          res_next.vgpr_write = 1'b0;  // Compares only write VCC
          res_next.vcc        = cmp_true;
        end
        default:                  res_next.vgpr_write = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      result <= '0;
    else if (result_load)
      result <= res_next;  // Held until the next completion
  end

endmodule

// ==== src/mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  simd_alu_pkg::word_t    opa,
  input  simd_alu_pkg::word_t    opb,
  output simd_alu_pkg::product_t product
);

  simd_alu_pkg::product_t prod_full;

  // Full unsigned product, both halves kept
  assign prod_full = {32'b0, opa} * {32'b0, opb};

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      product <= '0;
    else
      product <= prod_full;  // Free running, operands are stable while waiting
  end

endmodule

// ==== src/mul_cycle_counter.sv ====
`timescale 1ns/1ps

module mul_cycle_counter (
  input  logic clk,
  input  logic rst,
  input  logic run,
  output logic expired
);

  logic [simd_alu_pkg::MUL_CNT_W-1:0] cnt;

  assign expired = (cnt == simd_alu_pkg::MUL_CNT_LAST);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      cnt <= '0;
    else if (!run)
      cnt <= '0;
    else if (!expired)
      cnt <= cnt + 1'b1;  // Saturates at the last count
  end

  // The count only advances under run, so expiry must come from a running wait
  a_expired_needs_run: assert property (@(posedge clk) disable iff (rst)
    $rose(expired) |-> run);

endmodule

// ==== src/alu_ctrl_fsm.sv ====
`timescale 1ns/1ps

module alu_ctrl_fsm (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  simd_alu_pkg::decoded_op_t dec,
  input  logic                      expired,
  output logic                      load,
  output logic                      mul_run,
  output logic                      result_load,
  output logic                      busy,
  output logic                      done
);

  simd_alu_pkg::ctrl_state_e state;
  simd_alu_pkg::ctrl_state_e state_next;
  logic                      go_mul;

  assign go_mul      = dec.is_mul && dec.exec && !dec.illegal;
  assign load        = (state == simd_alu_pkg::st_idle) && start;
  assign mul_run     = (state == simd_alu_pkg::st_mul_wait);
  assign result_load = ((state == simd_alu_pkg::st_exec) && !go_mul) ||
                       ((state == simd_alu_pkg::st_mul_wait) && expired);
  assign busy        = (state != simd_alu_pkg::st_idle);

  always_comb
  begin
    state_next = state;
    case (state)
      simd_alu_pkg::st_idle:
        if (start)
          state_next = simd_alu_pkg::st_exec;
      simd_alu_pkg::st_exec:
        state_next = go_mul ? simd_alu_pkg::st_mul_wait : simd_alu_pkg::st_idle;
      simd_alu_pkg::st_mul_wait:
        if (expired)
          state_next = simd_alu_pkg::st_idle;
      default:
        state_next = simd_alu_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= simd_alu_pkg::st_idle;
      done  <= 1'b0;
    end
    else
    begin
      state <= state_next;
      done  <= result_load;  // Lines up with the result register update
    end
  end

  a_no_start_when_busy: assert property (@(posedge clk) disable iff (rst)
    busy |-> !start);

  // Completion and the return to idle happen on the same edge
  a_done_at_idle: assert property (@(posedge clk) disable iff (rst)
    done |-> !busy);

endmodule

// ==== src/simd_alu.sv ====
`timescale 1ns/1ps

module simd_alu (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  simd_alu_pkg::alu_req_t    req,
  output logic                      busy,
  output logic                      done,
  output simd_alu_pkg::alu_result_t result
);

  logic                      load;
  logic                      mul_run;
  logic                      expired;
  logic                      result_load;
  logic                      vcc_in;
  simd_alu_pkg::decoded_op_t dec;
  simd_alu_pkg::word_t       opa;
  simd_alu_pkg::word_t       opb;
  simd_alu_pkg::product_t    product;

  alu_ctrl_fsm u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .dec         (dec),
    .expired     (expired),
    .load        (load),
    .mul_run     (mul_run),
    .result_load (result_load),
    .busy        (busy),
    .done        (done)
  );

  mul_cycle_counter u_mul_cnt (
    .clk     (clk),
    .rst     (rst),
    .run     (mul_run),
    .expired (expired)
  );

  instr_decoder u_dec (
    .clk  (clk),
    .rst  (rst),
    .load (load),
    .ctrl (req.ctrl),
    .exec (req.exec),
    .dec  (dec)
  );

  operand_modifier u_opmod (
    .clk    (clk),
    .rst    (rst),
    .load   (load),
    .req    (req),
    .opa    (opa),
    .opb    (opb),
    .vcc_in (vcc_in)
  );

  vector_int_unit u_int (
    .clk         (clk),
    .rst         (rst),
    .result_load (result_load),
    .dec         (dec),
    .opa         (opa),
    .opb         (opb),
    .vcc_in      (vcc_in),
    .product     (product),
    .result      (result)
  );

  mul_unit u_mul (
    .clk     (clk),
    .rst     (rst),
    .opa     (opa),
    .opb     (opb),
    .product (product)
  );

endmodule

// ==== bench/alu_ref_model.svh ====
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// VOP3A source modifier, magnitude first and then negation
function automatic simd_alu_pkg::word_t model_modify(input simd_alu_pkg::word_t src,
                                                     input logic abs_en,
                                                     input logic neg_en);
  simd_alu_pkg::word_t val;
  val = src;
  if (abs_en && src[31])
    val = ~src + 32'd1;
  if (neg_en)
    val = ~val + 32'd1;
  return val;
endfunction

function automatic logic model_compare(input logic [2:0] cond, input logic uns,
                                       input simd_alu_pkg::word_t a,
                                       input simd_alu_pkg::word_t b);
  longint sa;
  longint sb;
  if (uns)
  begin
    sa = longint'({32'b0, a});
    sb = longint'({32'b0, b});
  end
  else
  begin
    sa = longint'($signed(a));  // Sign extended to 64 bits
    sb = longint'($signed(b));
  end
  case (cond)
    3'd0:    return 1'b0;
    3'd1:    return sa < sb;
    3'd2:    return sa == sb;
    3'd3:    return sa <= sb;
    3'd4:    return sa > sb;
    3'd5:    return sa != sb;
    3'd6:    return sa >= sb;
    default: return 1'b1;
  endcase
endfunction

// Predicts the held result register for one request
function automatic simd_alu_pkg::alu_result_t model_result(input simd_alu_pkg::alu_req_t req);
  simd_alu_pkg::alu_result_t res;
  logic [7:0]                fmt;
  simd_alu_pkg::opcode_t     opc;
  simd_alu_pkg::word_t       a;
  simd_alu_pkg::word_t       b;
  logic [32:0]               wide;
  logic [63:0]               prod;
  logic                      v3;
  logic                      is_cmp;
  fmt    = req.ctrl[31:24];
  opc    = req.ctrl[11:0];
  v3     = (fmt == simd_alu_pkg::fmt_vop3a);
  is_cmp = (v3 || fmt == simd_alu_pkg::fmt_vopc) &&
           (((opc & 12'hFF8) == simd_alu_pkg::OPC_V_CMP_I32_BASE) ||
            ((opc & 12'hFF8) == simd_alu_pkg::OPC_V_CMP_U32_BASE));
  a      = v3 ? model_modify(req.src1, req.ctrl[16], req.ctrl[20]) : req.src1;
  b      = v3 ? model_modify(req.src2, req.ctrl[17], req.ctrl[21]) : req.src2;
  res    = '0;
  res.vcc = req.vcc;
  if (!req.exec)
    return res;
  if (is_cmp)
  begin
    res.vcc = model_compare(opc[2:0], opc[6], a, b);
    return res;
  end
  res.vgpr_write = 1'b1;
  case ({fmt, opc})
    {simd_alu_pkg::fmt_vop1, simd_alu_pkg::OPC_V_MOV_B32}:
      res.vgpr_data = a;
    {simd_alu_pkg::fmt_vop2, simd_alu_pkg::OPC_V_ADD_I32}:
    begin
      wide          = {1'b0, a} + {1'b0, b};
      res.vgpr_data = wide[31:0];
      res.vcc       = wide[32];
    end
    {simd_alu_pkg::fmt_vop2, simd_alu_pkg::OPC_V_SUB_I32}:
    begin
      wide          = {1'b0, a} - {1'b0, b};
      res.vgpr_data = wide[31:0];
      res.vcc       = wide[32];  // Borrow
    end
    {simd_alu_pkg::fmt_vop2, simd_alu_pkg::OPC_V_SUBREV_I32}:
    begin
      wide          = {1'b0, b} - {1'b0, a};
      res.vgpr_data = wide[31:0];
      res.vcc       = wide[32];
    end
    {simd_alu_pkg::fmt_vop2, simd_alu_pkg::OPC_V_ADDC_U32}:
    begin
      wide          = {1'b0, a} + {1'b0, b} + {32'b0, req.vcc};
      res.vgpr_data = wide[31:0];
      res.vcc       = wide[32];
    end
    {simd_alu_pkg::fmt_vop2, simd_alu_pkg::OPC_V_AND_B32},
    {simd_alu_pkg::fmt_vop3a, simd_alu_pkg::OPC_V3_AND_B32}:
      res.vgpr_data = a & b;
    {simd_alu_pkg::fmt_vop2, simd_alu_pkg::OPC_V_OR_B32}:
      res.vgpr_data = a | b;
    {simd_alu_pkg::fmt_vop2, simd_alu_pkg::OPC_V_LSHLREV_B32}:
      res.vgpr_data = b << a[4:0];
    {simd_alu_pkg::fmt_vop2, simd_alu_pkg::OPC_V_LSHRREV_B32}:
      res.vgpr_data = b >> a[4:0];
    {simd_alu_pkg::fmt_vop2, simd_alu_pkg::OPC_V_ASHRREV_I32}:
      res.vgpr_data = (b >> a[4:0]) | (b[31] ? ~(32'hffff_ffff >> a[4:0]) : 32'h0);
    {simd_alu_pkg::fmt_vop2, simd_alu_pkg::OPC_V_MAX_U32},
    {simd_alu_pkg::fmt_vop3a, simd_alu_pkg::OPC_V3_MAX_U32}:
      res.vgpr_data = (a > b) ? a : b;
    {simd_alu_pkg::fmt_vop2, simd_alu_pkg::OPC_V_MAX_I32}:
      res.vgpr_data = (longint'($signed(a)) > longint'($signed(b))) ? a : b;
    {simd_alu_pkg::fmt_vop2, simd_alu_pkg::OPC_V_MIN_U32}:
      res.vgpr_data = (a < b) ? a : b;
    {simd_alu_pkg::fmt_vop2, simd_alu_pkg::OPC_V_CNDMASK_B32}:
      res.vgpr_data = req.vcc ? b : a;
    {simd_alu_pkg::fmt_vop3a, simd_alu_pkg::OPC_V_MUL_LO_U32}:
    begin
      prod          = 64'(a) * 64'(b);
      res.vgpr_data = prod[31:0];
    end
    {simd_alu_pkg::fmt_vop3a, simd_alu_pkg::OPC_V_MUL_HI_U32}:
    begin
      prod          = 64'(a) * 64'(b);
      res.vgpr_data = prod[63:32];
    end
    default:
    begin
      res.vgpr_write = 1'b0;  // Unsupported format and opcode pair
      res.illegal    = 1'b1;
    end
  endcase
  return res;
endfunction

`endif

// ==== bench/tb_simd_alu.sv ====
`timescale 1ns/1ps

module tb_simd_alu;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 10;
  localparam int DONE_LIMIT   = 10;  // Edges allowed before done counts as missing
  localparam int N_SINGLE     = 200;
  localparam int N_CMP_ROUNDS = 4;
  localparam int N_MOD        = 100;
  localparam int N_MUL        = 40;
  localparam int N_MASK       = 40;
  localparam int N_ILLEGAL    = 40;
  localparam int TOTAL_OPS    = N_SINGLE + 32 * N_CMP_ROUNDS + N_MOD + N_MUL + N_MASK +
                                N_ILLEGAL;
  localparam int WATCHDOG_NS  = (TOTAL_OPS * 6 + RESET_CYCLES) * CLK_PERIOD;

  logic                      clk;
  logic                      rst;
  logic                      start;
  simd_alu_pkg::alu_req_t    req;
  logic                      busy;
  logic                      done;
  simd_alu_pkg::alu_result_t result;

  logic [31:0] lcg_state = 32'hb24c_d886;
  int          checks;
  int          value_errors;
  int          protocol_errors;

  `include "alu_ref_model.svh"

  simd_alu dut0 (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .req    (req),
    .busy   (busy),
    .done   (done),
    .result (result)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Corner values now and then, otherwise full range
  function automatic simd_alu_pkg::word_t rand_operand();
    logic [31:0] r;
    r = next_rand();
    case (r[3:0])
      4'd0:    return 32'h0;
      4'd1:    return 32'h8000_0000;
      4'd2:    return 32'hffff_ffff;
      4'd3:    return 32'(r[11:4]);
      default: return next_rand();
    endcase
  endfunction

  function automatic simd_alu_pkg::opcode_t vop2_opcode(input int idx);
    case (idx)
      0:       return simd_alu_pkg::OPC_V_ADD_I32;
      1:       return simd_alu_pkg::OPC_V_SUB_I32;
      2:       return simd_alu_pkg::OPC_V_SUBREV_I32;
      3:       return simd_alu_pkg::OPC_V_ADDC_U32;
      4:       return simd_alu_pkg::OPC_V_AND_B32;
      5:       return simd_alu_pkg::OPC_V_OR_B32;
      6:       return simd_alu_pkg::OPC_V_LSHLREV_B32;
      7:       return simd_alu_pkg::OPC_V_LSHRREV_B32;
      8:       return simd_alu_pkg::OPC_V_ASHRREV_I32;
      9:       return simd_alu_pkg::OPC_V_MAX_U32;
      10:      return simd_alu_pkg::OPC_V_MAX_I32;
      11:      return simd_alu_pkg::OPC_V_MIN_U32;
      default: return simd_alu_pkg::OPC_V_CNDMASK_B32;
    endcase
  endfunction

  // Format in bits 19:12, opcode in bits 11:0
  function automatic logic [19:0] illegal_encoding(input int idx);
    case (idx)
      0:       return {simd_alu_pkg::fmt_vop2, simd_alu_pkg::OPC_V_MUL_LO_U32};
      1:       return {simd_alu_pkg::fmt_vop1, simd_alu_pkg::OPC_V_MUL_HI_U32};
      2:       return {simd_alu_pkg::fmt_vop2, simd_alu_pkg::OPC_V3_MAX_U32};
      3:       return {simd_alu_pkg::fmt_vopc, simd_alu_pkg::OPC_V_ADD_I32};
      4:       return {simd_alu_pkg::fmt_vop3a, simd_alu_pkg::OPC_V_ADD_I32};
      5:       return {simd_alu_pkg::fmt_vop1, simd_alu_pkg::OPC_V_AND_B32};
      6:       return {simd_alu_pkg::fmt_vop2, 12'h083};  // Compare outside VOPC
      default: return {8'h10, simd_alu_pkg::OPC_V_MOV_B32};  // Unknown format
    endcase
  endfunction

  // Random bits land in ctrl[23:12], which holds the abs and neg flags
  function automatic simd_alu_pkg::alu_req_t build_req(input logic [7:0] fmt,
                                                        input simd_alu_pkg::opcode_t opc,
                                                        input logic exec);
    simd_alu_pkg::alu_req_t r;
    logic [31:0]            mods;
    mods   = next_rand();
    r.ctrl = {fmt, mods[11:0], opc};
    r.src1 = rand_operand();
    r.src2 = (mods[31:29] == 3'b000) ? r.src1 : rand_operand();
    r.vcc  = mods[28];
    r.exec = exec;
    return r;
  endfunction

  task automatic check_field(input string test_name, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act)
    begin
      value_errors++;
      $display("CHECK FAILED %s: %s expected 0x%0h actual 0x%0h", test_name, field, exp, act);
    end
  endtask

  // Starts at a falling edge, returns at the falling edge after done
  task automatic run_op(input string test_name, input simd_alu_pkg::alu_req_t op_req,
                        input int exp_edges);
    simd_alu_pkg::alu_result_t exp_res;
    int                        edges;
    logic                      got_done;
    exp_res  = model_result(op_req);
    req      = op_req;
    start    = 1'b1;
    @(posedge clk);  // Load edge
    @(negedge clk);
    start    = 1'b0;
    check_field(test_name, "busy after load", 32'd1, 32'(busy));
    edges    = 0;
    got_done = 1'b0;
    while (!got_done && edges < DONE_LIMIT)
    begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      if (done)
        got_done = 1'b1;
      else
        check_field(test_name, "busy while waiting", 32'd1, 32'(busy));
    end
    if (!got_done)
    begin
      protocol_errors++;
      $display("ERROR %s: done did not arrive within %0d cycles of the load edge",
               test_name, DONE_LIMIT);
      return;
    end
    check_field(test_name, "done edge", 32'(exp_edges), 32'(edges));
    check_field(test_name, "busy after done", 32'd0, 32'(busy));
    check_field(test_name, "vgpr_write", 32'(exp_res.vgpr_write), 32'(result.vgpr_write));
    check_field(test_name, "vcc", 32'(exp_res.vcc), 32'(result.vcc));
    check_field(test_name, "illegal", 32'(exp_res.illegal), 32'(result.illegal));
    if (exp_res.vgpr_write)
      check_field(test_name, "vgpr_data", exp_res.vgpr_data, result.vgpr_data);
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("ERROR watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    simd_alu_pkg::alu_req_t op_req;
    simd_alu_pkg::opcode_t  opc;
    logic [31:0]            r;
    logic [19:0]            enc;
    int                     sel;
    clk             = 1'b0;
    rst             = 1'b1;
    start           = 1'b0;
    req             = '0;
    checks          = 0;
    value_errors    = 0;
    protocol_errors = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_field("reset", "busy", 32'd0, 32'(busy));
    check_field("reset", "done", 32'd0, 32'(done));
    check_field("reset", "vgpr_write", 32'd0, 32'(result.vgpr_write));
    check_field("reset", "illegal", 32'd0, 32'(result.illegal));

    for (int i = 0; i < N_SINGLE; i++)
    begin
      r   = next_rand();
      sel = r % 14;
      if (sel == 0)
        op_req = build_req(simd_alu_pkg::fmt_vop1, simd_alu_pkg::OPC_V_MOV_B32, 1'b1);
      else
        op_req = build_req(simd_alu_pkg::fmt_vop2, vop2_opcode(sel - 1), 1'b1);
      run_op("single_cycle", op_req, 1);
    end

    // Every condition, signed and unsigned, in both compare formats
    for (int f = 0; f < 2; f++)
      for (int c = 0; c < 16; c++)
        for (int k = 0; k < N_CMP_ROUNDS; k++)
        begin
          opc = (c < 8) ? simd_alu_pkg::OPC_V_CMP_I32_BASE : simd_alu_pkg::OPC_V_CMP_U32_BASE;
          opc = opc | simd_alu_pkg::opcode_t'(c % 8);
          op_req = build_req((f == 0) ? simd_alu_pkg::fmt_vopc : simd_alu_pkg::fmt_vop3a,
                             opc, 1'b1);
          run_op("compare", op_req, 1);
        end

    for (int i = 0; i < N_MOD; i++)
    begin
      r = next_rand();
      case (r[1:0])
        2'd0:    opc = simd_alu_pkg::OPC_V3_AND_B32;
        2'd1:    opc = simd_alu_pkg::OPC_V3_MAX_U32;
        2'd2:    opc = simd_alu_pkg::OPC_V_CMP_I32_BASE | simd_alu_pkg::opcode_t'(r[4:2]);
        default: opc = simd_alu_pkg::OPC_V_CMP_U32_BASE | simd_alu_pkg::opcode_t'(r[4:2]);
      endcase
      op_req = build_req(simd_alu_pkg::fmt_vop3a, opc, 1'b1);
      run_op("vop3a_modifiers", op_req, 1);
    end

    for (int i = 0; i < N_MUL; i++)
    begin
      r   = next_rand();
      opc = r[2] ? simd_alu_pkg::OPC_V_MUL_HI_U32 : simd_alu_pkg::OPC_V_MUL_LO_U32;
      op_req = build_req(simd_alu_pkg::fmt_vop3a, opc, 1'b1);
      run_op("multiply", op_req, 1 + simd_alu_pkg::MUL_WAIT_CYCLES);
    end

    for (int i = 0; i < N_MASK; i++)
    begin
      r   = next_rand();
      sel = r[31:8] % 13;
      case (r[1:0])
        2'd0: op_req = build_req(simd_alu_pkg::fmt_vop1, simd_alu_pkg::OPC_V_MOV_B32, 1'b0);
        2'd1: op_req = build_req(simd_alu_pkg::fmt_vop2, vop2_opcode(sel), 1'b0);
        2'd2:
        begin
          opc = r[5] ? simd_alu_pkg::OPC_V_CMP_U32_BASE : simd_alu_pkg::OPC_V_CMP_I32_BASE;
          opc = opc | simd_alu_pkg::opcode_t'(r[4:2]);
          op_req = build_req(simd_alu_pkg::fmt_vopc, opc, 1'b0);
        end
        default:
        begin
          opc = r[2] ? simd_alu_pkg::OPC_V_MUL_HI_U32 : simd_alu_pkg::OPC_V_MUL_LO_U32;
          op_req = build_req(simd_alu_pkg::fmt_vop3a, opc, 1'b0);  // Masked multiply is fast
        end
      endcase
      run_op("exec_low", op_req, 1);
    end

    for (int i = 0; i < N_ILLEGAL; i++)
    begin
      r      = next_rand();
      enc    = illegal_encoding(r[31:8] % 8);
      op_req = build_req(enc[19:12], enc[11:0], 1'b1);
      run_op("illegal", op_req, 1);
    end

    $display("Summary: %0d checks, %0d value errors, %0d protocol errors",
             checks, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// ==== simd_alu.f ====
+incdir+bench
src/simd_alu_pkg.sv
src/instr_decoder.sv
src/operand_modifier.sv
src/vector_int_unit.sv
src/mul_unit.sv
src/mul_cycle_counter.sv
src/alu_ctrl_fsm.sv
src/simd_alu.sv
bench/tb_simd_alu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the simd_alu testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_simd_alu \
  -f simd_alu.f -o tb_simd_alu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_simd_alu > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "All tests passed" "$LOG"; then
  exit 0
else
  exit 1
fi
